/* common/conv_arith_pkg.sv */
package conv_arith_pkg;

    //////////////////////////////////////////////////
    // Accumulation

    // PE and router sums
    // Wide enough for any 8x8 product summed over a small window
    localparam int DEF_ACC_WIDTH = 32;

    //////////////////////////////////////////////////
    // Output saturation

    // Clip range of the 8-bit signed result
    localparam int SAT_MAX = 127;
    localparam int SAT_MIN = -128;

    // Result width implied by the clip range
    localparam int SAT_WIDTH = 8;

    // Largest single product magnitude, 8-bit by 8-bit signed
    localparam int PROD_MAX = 128 * 128;

    // Headroom left in the accumulator above one product
    localparam int ACC_HEADROOM = DEF_ACC_WIDTH - 2 * SAT_WIDTH;

endpackage

/* common/conv_geometry_pkg.sv */
package conv_geometry_pkg;

    //////////////////////////////////////////////////
    // Element size

    // One data or weight element, two's complement
    localparam int DEF_BIT_WIDTH = 8;

    //////////////////////////////////////////////////
    // Array shape

    // Channels packed into one pixel word
    localparam int DEF_NUM_CHANNEL = 3;

    // Kernels evaluated side by side on the same window
    localparam int DEF_NUM_KERNEL = 4;

    // Window taps
    // One kernel-channel PE is built per tap
    localparam int DEF_NUM_POS = 3;

    // Channel 0 sits in the low bits of a pixel word, and kernel 0 in
    // the low bits of a weight word
    localparam int DEF_PIXEL_ELEMS  = DEF_NUM_CHANNEL;
    localparam int DEF_WEIGHT_ELEMS = DEF_NUM_CHANNEL * DEF_NUM_KERNEL;

endpackage

/* common/psum_bus_if.sv */
`timescale 1ns/100ps

interface psum_bus_if ();
    import conv_geometry_pkg::*;
    import conv_arith_pkg::*;

    parameter int NUM_KERNEL = DEF_NUM_KERNEL;
    parameter int NUM_POS    = DEF_NUM_POS;
    parameter int ACC_WIDTH  = DEF_ACC_WIDTH;

    // Each PE drives only its own position slice
    wire [NUM_POS-1:0][NUM_KERNEL-1:0][ACC_WIDTH-1:0] psum;

    // One valid bit per position
    wire [NUM_POS-1:0] psum_val;

    // PE side
    modport pe (
        output psum,
        output psum_val
    );

    // Router side
    modport rt (
        input psum,
        input psum_val
    );

endinterface

/* common/window_if.sv */
`timescale 1ns/100ps

interface window_if ();
    import conv_geometry_pkg::*;

    parameter int BIT_WIDTH   = DEF_BIT_WIDTH;
    parameter int NUM_CHANNEL = DEF_NUM_CHANNEL;
    parameter int NUM_KERNEL  = DEF_NUM_KERNEL;
    parameter int NUM_POS     = DEF_NUM_POS;

    // Sliding window, position 0 holds the oldest pixel
    logic [NUM_POS-1:0][NUM_CHANNEL-1:0][BIT_WIDTH-1:0] win_data;

    // Window complete, one cycle per accepted pixel
    logic win_val;

    // Tap weights by position, kernel, channel
    logic [NUM_POS-1:0][NUM_KERNEL-1:0][NUM_CHANNEL-1:0][BIT_WIDTH-1:0] tap_weight;

    // High once the full tap set is stored
    logic taps_loaded;

    // Buffer side, window and weight stores each drive their own half
    modport src (
        output win_data,
        output win_val,
        output tap_weight,
        output taps_loaded
    );

    // PE side
    modport pe (
        input win_data,
        input win_val,
        input tap_weight
    );

endinterface

/* compile.f */
common/conv_geometry_pkg.sv
common/conv_arith_pkg.sv
common/window_if.sv
common/psum_bus_if.sv
design/line_input_window.sv
design/tap_weight_store.sv
design/kernel_channel_pe.sv
design/result_router.sv
design/line_kcpe_conv2d_engine.sv
verif/conv_engine_properties.sv
verif/tb_line_kcpe_conv2d_engine.sv

/* design/kernel_channel_pe.sv */
`timescale 1ns/100ps

module kernel_channel_pe #(
    parameter int BIT_WIDTH   = conv_geometry_pkg::DEF_BIT_WIDTH,
    parameter int NUM_CHANNEL = conv_geometry_pkg::DEF_NUM_CHANNEL,
    parameter int NUM_KERNEL  = conv_geometry_pkg::DEF_NUM_KERNEL,
    parameter int NUM_POS     = conv_geometry_pkg::DEF_NUM_POS,
    parameter int ACC_WIDTH   = conv_arith_pkg::DEF_ACC_WIDTH,
    parameter int POS         = 0
) (
    input  logic   clk,
    input  logic   i_reset,
    window_if.pe   win_if,
    psum_bus_if.pe psum_if
);

    logic signed [ACC_WIDTH-1:0]          kn_sum [NUM_KERNEL];
    logic [NUM_KERNEL-1:0][ACC_WIDTH-1:0] psum_q;
    logic                                 psum_val_q;

    //////////////////////////////////////////////////
    // Dot product over channels, one per kernel

    always_comb begin : mac_sum
        logic signed [BIT_WIDTH-1:0] pix;
        logic signed [BIT_WIDTH-1:0] wgt;
        pix = '0;
        wgt = '0;
        for (int k = 0; k < NUM_KERNEL; k++) begin
            kn_sum[k] = '0;
            for (int c = 0; c < NUM_CHANNEL; c++) begin
                pix = win_if.win_data[POS][c];
                wgt = win_if.tap_weight[POS][k][c];
                // Operands widen to ACC_WIDTH before the multiply
                kn_sum[k] = kn_sum[k] + pix * wgt;
            end
        end
    end

    //////////////////////////////////////////////////
    // Output stage

    always_ff @(posedge clk) begin
        if (i_reset) begin
            psum_val_q <= 1'b0;
        end else begin
            psum_val_q <= win_if.win_val;
        end
    end

    // Sums only move on a valid window
    always_ff @(posedge clk) begin
        if (win_if.win_val) begin
            for (int k = 0; k < NUM_KERNEL; k++) begin
                psum_q[k] <= kn_sum[k];
            end
        end
    end

    assign psum_if.psum[POS]     = psum_q;
    assign psum_if.psum_val[POS] = psum_val_q;

endmodule

/* design/line_input_window.sv */
`timescale 1ns/100ps

module line_input_window #(
    parameter int BIT_WIDTH   = conv_geometry_pkg::DEF_BIT_WIDTH,
    parameter int NUM_CHANNEL = conv_geometry_pkg::DEF_NUM_CHANNEL,
    parameter int NUM_KERNEL  = conv_geometry_pkg::DEF_NUM_KERNEL,
    parameter int NUM_POS     = conv_geometry_pkg::DEF_NUM_POS
) (
    input  logic                             clk,
    input  logic                             i_reset,
    input  logic [BIT_WIDTH*NUM_CHANNEL-1:0] i_data,
    input  logic                             i_data_val,
    window_if.src                            win_if
);

    localparam int CNT_W = $clog2(NUM_POS + 1);

    logic [NUM_POS-1:0][NUM_CHANNEL-1:0][BIT_WIDTH-1:0] win_q;
    logic [CNT_W-1:0]                                   fill_cnt;
    logic                                               win_val_q;
    logic                                               pix_acc;
    logic                                               win_full;

    //////////////////////////////////////////////////
    // Acceptance

    // Data request is the loaded flag, so it also gates the data path
    assign pix_acc = i_data_val && win_if.taps_loaded;

    // Full after this pixel
    assign win_full = (fill_cnt >= CNT_W'(NUM_POS - 1));

    //////////////////////////////////////////////////
    // Window shift register

    always_ff @(posedge clk) begin
        if (i_reset) begin
            win_q <= '0;
        end else if (pix_acc) begin
            // Older pixels move toward position 0
            for (int p = 0; p < NUM_POS - 1; p++) begin
                win_q[p] <= win_q[p+1];
            end
            win_q[NUM_POS-1] <= i_data;
        end
    end

    // Fill count stops at NUM_POS
    always_ff @(posedge clk) begin
        if (i_reset) begin
            fill_cnt <= '0;
        end else if (pix_acc && (fill_cnt != CNT_W'(NUM_POS))) begin
            fill_cnt <= fill_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            win_val_q <= 1'b0;
        end else begin
            win_val_q <= pix_acc && win_full;
        end
    end

    assign win_if.win_data = win_q;
    assign win_if.win_val  = win_val_q;

endmodule

/* design/line_kcpe_conv2d_engine.sv */
`timescale 1ns/100ps

module line_kcpe_conv2d_engine #(
    parameter int BIT_WIDTH   = conv_geometry_pkg::DEF_BIT_WIDTH,
    parameter int NUM_CHANNEL = conv_geometry_pkg::DEF_NUM_CHANNEL,
    parameter int NUM_KERNEL  = conv_geometry_pkg::DEF_NUM_KERNEL,
    parameter int NUM_POS     = conv_geometry_pkg::DEF_NUM_POS,
    parameter int ACC_WIDTH   = conv_arith_pkg::DEF_ACC_WIDTH
) (
    input  logic                                        clk,
    input  logic                                        i_reset,
    input  logic [BIT_WIDTH*NUM_CHANNEL-1:0]            i_data,
    input  logic                                        i_data_val,
    input  logic [BIT_WIDTH*NUM_CHANNEL*NUM_KERNEL-1:0] i_weight,
    input  logic                                        i_weight_val,
    output logic                                        o_data_req,
    output logic                                        o_weight_req,
    output logic [BIT_WIDTH-1:0]                        o_psum_kn0,
    output logic [BIT_WIDTH-1:0]                        o_psum_kn1,
    output logic [BIT_WIDTH-1:0]                        o_psum_kn2,
    output logic [BIT_WIDTH-1:0]                        o_psum_kn3,
    output logic                                        o_psum_val
);

    logic [NUM_KERNEL-1:0][BIT_WIDTH-1:0] router_psum;

    //////////////////////////////////////////////////
    // Internal buses

    window_if #(
        .BIT_WIDTH   (BIT_WIDTH),
        .NUM_CHANNEL (NUM_CHANNEL),
        .NUM_KERNEL  (NUM_KERNEL),
        .NUM_POS     (NUM_POS)
    ) win_bus ();

    psum_bus_if #(
        .NUM_KERNEL (NUM_KERNEL),
        .NUM_POS    (NUM_POS),
        .ACC_WIDTH  (ACC_WIDTH)
    ) psum_bus ();

    //////////////////////////////////////////////////
    // Buffers

    tap_weight_store #(
        .BIT_WIDTH   (BIT_WIDTH),
        .NUM_CHANNEL (NUM_CHANNEL),
        .NUM_KERNEL  (NUM_KERNEL),
        .NUM_POS     (NUM_POS)
    ) tap_weight_store_0 (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_weight     (i_weight),
        .i_weight_val (i_weight_val),
        .o_weight_req (o_weight_req),
        .o_data_req   (o_data_req),
        .win_if       (win_bus)
    );

    line_input_window #(
        .BIT_WIDTH   (BIT_WIDTH),
        .NUM_CHANNEL (NUM_CHANNEL),
        .NUM_KERNEL  (NUM_KERNEL),
        .NUM_POS     (NUM_POS)
    ) line_input_window_0 (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_data     (i_data),
        .i_data_val (i_data_val),
        .win_if     (win_bus)
    );

    //////////////////////////////////////////////////
    // One PE per window position

    for (genvar p = 0; p < NUM_POS; p++) begin : g_kcpe
        kernel_channel_pe #(
            .BIT_WIDTH   (BIT_WIDTH),
            .NUM_CHANNEL (NUM_CHANNEL),
            .NUM_KERNEL  (NUM_KERNEL),
            .NUM_POS     (NUM_POS),
            .ACC_WIDTH   (ACC_WIDTH),
            .POS         (p)
        ) kernel_channel_pe_i (
            .clk     (clk),
            .i_reset (i_reset),
            .win_if  (win_bus),
            .psum_if (psum_bus)
        );
    end

    result_router #(
        .BIT_WIDTH   (BIT_WIDTH),
        .NUM_CHANNEL (NUM_CHANNEL),
        .NUM_KERNEL  (NUM_KERNEL),
        .NUM_POS     (NUM_POS),
        .ACC_WIDTH   (ACC_WIDTH)
    ) result_router_0 (
        .clk        (clk),
        .i_reset    (i_reset),
        .psum_if    (psum_bus),
        .o_psum     (router_psum),
        .o_psum_val (o_psum_val)
    );

    // Kernel lanes out to the plain ports
    assign o_psum_kn0 = router_psum[0];
    assign o_psum_kn1 = router_psum[1];
    assign o_psum_kn2 = router_psum[2];
    assign o_psum_kn3 = router_psum[3];

endmodule

/* design/result_router.sv */
`timescale 1ns/100ps

module result_router #(
    parameter int BIT_WIDTH   = conv_geometry_pkg::DEF_BIT_WIDTH,
    parameter int NUM_CHANNEL = conv_geometry_pkg::DEF_NUM_CHANNEL,
    parameter int NUM_KERNEL  = conv_geometry_pkg::DEF_NUM_KERNEL,
    parameter int NUM_POS     = conv_geometry_pkg::DEF_NUM_POS,
    parameter int ACC_WIDTH   = conv_arith_pkg::DEF_ACC_WIDTH
) (
    input  logic                                 clk,
    input  logic                                 i_reset,
    psum_bus_if.rt                               psum_if,
    output logic [NUM_KERNEL-1:0][BIT_WIDTH-1:0] o_psum,
    output logic                                 o_psum_val
);
    import conv_arith_pkg::*;

    logic signed [ACC_WIDTH-1:0]          kn_total [NUM_KERNEL];
    logic [NUM_KERNEL-1:0][BIT_WIDTH-1:0] kn_clip;
    logic                                 all_val;

    // All PEs fire together on a valid window
    assign all_val = &psum_if.psum_val;

    //////////////////////////////////////////////////
    // Sum across positions

    always_comb begin
        for (int k = 0; k < NUM_KERNEL; k++) begin
            kn_total[k] = '0;
            for (int p = 0; p < NUM_POS; p++) begin
                kn_total[k] = kn_total[k] + $signed(psum_if.psum[p][k]);
            end
        end
    end

    // Clip to the 8-bit signed range
    always_comb begin
        for (int k = 0; k < NUM_KERNEL; k++) begin
            if (kn_total[k] > SAT_MAX) begin
                kn_clip[k] = BIT_WIDTH'(SAT_MAX);
            end else if (kn_total[k] < SAT_MIN) begin
                kn_clip[k] = BIT_WIDTH'(SAT_MIN);
            end else begin
                kn_clip[k] = kn_total[k][BIT_WIDTH-1:0];
            end
        end
    end

    //////////////////////////////////////////////////
    // Output registers

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_psum_val <= 1'b0;
        end else begin
            o_psum_val <= all_val;
        end
    end

    always_ff @(posedge clk) begin
        if (all_val) begin
            o_psum <= kn_clip;
        end
    end

endmodule

/* design/tap_weight_store.sv */
`timescale 1ns/100ps

module tap_weight_store #(
    parameter int BIT_WIDTH   = conv_geometry_pkg::DEF_BIT_WIDTH,
    parameter int NUM_CHANNEL = conv_geometry_pkg::DEF_NUM_CHANNEL,
    parameter int NUM_KERNEL  = conv_geometry_pkg::DEF_NUM_KERNEL,
    parameter int NUM_POS     = conv_geometry_pkg::DEF_NUM_POS
) (
    input  logic                                        clk,
    input  logic                                        i_reset,
    input  logic [BIT_WIDTH*NUM_CHANNEL*NUM_KERNEL-1:0] i_weight,
    input  logic                                        i_weight_val,
    output logic                                        o_weight_req,
    output logic                                        o_data_req,
    window_if.src                                       win_if
);

    localparam int CNT_W = $clog2(NUM_POS + 1);

    logic [NUM_POS-1:0][NUM_KERNEL-1:0][NUM_CHANNEL-1:0][BIT_WIDTH-1:0] tap_q;
    logic [CNT_W-1:0] tap_cnt;
    logic             loaded_q;
    logic             weight_acc;

    // Weight words are taken only while the tap set is incomplete
    assign weight_acc = i_weight_val && !loaded_q;

    //////////////////////////////////////////////////
    // Tap counter and load state

    always_ff @(posedge clk) begin
        if (i_reset) begin
            tap_cnt  <= '0;
            loaded_q <= 1'b0;
        end else if (weight_acc) begin
            tap_cnt <= tap_cnt + 1'b1;
            // Last tap word switches the engine over to data
            if (tap_cnt == CNT_W'(NUM_POS - 1)) begin
                loaded_q <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Tap registers, position 0 first

    always_ff @(posedge clk) begin
        if (i_reset) begin
            tap_q <= '0;
        end else if (weight_acc) begin
            tap_q[tap_cnt] <= i_weight;
        end
    end

    // Requests swap on the edge that takes the last tap
    assign o_weight_req = !loaded_q;
    assign o_data_req   = loaded_q;

    assign win_if.tap_weight  = tap_q;
    assign win_if.taps_loaded = loaded_q;

endmodule

/* verif/conv_engine_properties.sv */
`timescale 1ns/100ps

module conv_engine_properties (
    input logic clk,
    input logic i_reset,
    input logic o_data_req,
    input logic o_weight_req,
    input logic o_psum_val
);

    //////////////////////////////////////////////////
    // Request exclusivity

    // Engine is either loading taps or taking pixels
    req_exclusive: assert property (
        @(posedge clk) disable iff (i_reset)
        !(o_weight_req && o_data_req)
    ) else $error("weight and data requests are both high");

    //////////////////////////////////////////////////
    // Reset and load phase

    // Synchronous reset, outputs settle one edge later
    reset_quiet: assert property (
        @(posedge clk)
        i_reset |=> (!o_psum_val && !o_data_req)
    ) else $error("output valid or data request high during reset");

    no_output_while_loading: assert property (
        @(posedge clk) disable iff (i_reset)
        o_weight_req |-> !o_psum_val
    ) else $error("output valid while taps are still loading");

endmodule

bind line_kcpe_conv2d_engine conv_engine_properties i_conv_engine_properties (
    .clk          (clk),
    .i_reset      (i_reset),
    .o_data_req   (o_data_req),
    .o_weight_req (o_weight_req),
    .o_psum_val   (o_psum_val)
);

/* verif/tb_line_kcpe_conv2d_engine.sv */
`timescale 1ns/100ps

module tb_line_kcpe_conv2d_engine;
    import conv_geometry_pkg::*;
    import conv_arith_pkg::*;

    localparam int BIT_WIDTH   = DEF_BIT_WIDTH;
    localparam int NUM_CHANNEL = DEF_NUM_CHANNEL;
    localparam int NUM_KERNEL  = DEF_NUM_KERNEL;
    localparam int NUM_POS     = DEF_NUM_POS;
    localparam int D_WORD      = BIT_WIDTH * NUM_CHANNEL;
    localparam int W_WORD      = BIT_WIDTH * NUM_CHANNEL * NUM_KERNEL;
    localparam int O_WORD      = BIT_WIDTH * NUM_KERNEL;
    localparam int NUM_ROWS    = 6;
    localparam int MAX_OFFER   = 12;
    localparam int WAIT_LIMIT  = 20;

    logic              clk = 1'b0;
    logic              i_reset;
    logic [D_WORD-1:0] i_data;
    logic              i_data_val;
    logic [W_WORD-1:0] i_weight;
    logic              i_weight_val;
    logic              o_data_req;
    logic              o_weight_req;
    logic [7:0]        o_psum_kn0;
    logic [7:0]        o_psum_kn1;
    logic [7:0]        o_psum_kn2;
    logic [7:0]        o_psum_kn3;
    logic              o_psum_val;

    //////////////////////////////////////////////////
    // Stimulus table, one row per test

    string             row_name   [NUM_ROWS];
    logic [W_WORD-1:0] row_weight [NUM_ROWS][NUM_POS];
    logic [D_WORD-1:0] row_pix    [NUM_ROWS][MAX_OFFER];
    bit                row_val    [NUM_ROWS][MAX_OFFER];
    int                row_len    [NUM_ROWS];
    bit                row_cut    [NUM_ROWS];

    // Expected results and the cycle each one is due
    logic [O_WORD-1:0] exp_out [$];
    int                due_q   [$];
    int                out_idx;
    int                cyc;

    line_kcpe_conv2d_engine #(
        .BIT_WIDTH   (BIT_WIDTH),
        .NUM_CHANNEL (NUM_CHANNEL),
        .NUM_KERNEL  (NUM_KERNEL),
        .NUM_POS     (NUM_POS),
        .ACC_WIDTH   (DEF_ACC_WIDTH)
    ) i_line_kcpe_conv2d_engine (.*);

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string test, input string what,
                                   input logic signed [31:0] expv,
                                   input logic signed [31:0] actv);
        $display("CHECK FAILED %s %s expected %0d actual %0d", test, what, expv, actv);
        abort_run();
    endtask

    function automatic logic [W_WORD-1:0] rand_word(input int n, input int lo, input int hi);
        logic [W_WORD-1:0] w;
        int                x;
        w = '0;
        for (int e = 0; e < n; e++) begin
            x = lo + int'($urandom % (hi - lo + 1));
            w[e*BIT_WIDTH +: BIT_WIDTH] = x[BIT_WIDTH-1:0];
        end
        return w;
    endfunction

    function automatic int elem_at(input logic [W_WORD-1:0] word, input int idx);
        logic signed [BIT_WIDTH-1:0] e;
        e = word[idx*BIT_WIDTH +: BIT_WIDTH];
        return e;
    endfunction

    function automatic logic [BIT_WIDTH-1:0] clip_to_byte(input int total);
        if (total > SAT_MAX) return BIT_WIDTH'(SAT_MAX);
        if (total < SAT_MIN) return BIT_WIDTH'(SAT_MIN);
        return total[BIT_WIDTH-1:0];
    endfunction

    task automatic fill_row(input int r, input string name, input int w_lo, input int w_hi,
                            input int p_lo, input int p_hi, input int len, input bit cut);
        row_name[r] = name;
        row_len[r]  = len;
        row_cut[r]  = cut;
        for (int p = 0; p < NUM_POS; p++) begin
            row_weight[r][p] = rand_word(NUM_CHANNEL * NUM_KERNEL, w_lo, w_hi);
        end
        for (int i = 0; i < MAX_OFFER; i++) begin
            row_pix[r][i] = D_WORD'(rand_word(NUM_CHANNEL, p_lo, p_hi));
            row_val[r][i] = 1'b1;
        end
    endtask

    task automatic build_table();
        fill_row(0, "small_random", -3, 3, -3, 3, 8, 1'b0);
        fill_row(1, "gapped_input", -3, 3, -3, 3, 12, 1'b0);
        // Every third slot idle, data still toggles
        for (int i = 0; i < MAX_OFFER; i++) begin
            row_val[1][i] = (i % 3) != 0;
        end
        fill_row(2, "clip_positive", 64, 127, 64, 127, 6, 1'b0);
        fill_row(3, "clip_negative", -128, -64, 64, 127, 6, 1'b0);
        fill_row(4, "midstream_reset", -3, 3, -3, 3, 6, 1'b1);
        fill_row(5, "reload_weights", -3, 3, -3, 3, 8, 1'b0);
    endtask

    // Reference model straight from the dot-product rule
    task automatic compute_expected(input int r);
        logic [D_WORD-1:0] acc_pix [$];
        logic [O_WORD-1:0] word;
        int                total;
        exp_out.delete();
        for (int i = 0; i < row_len[r]; i++) begin
            if (row_val[r][i]) acc_pix.push_back(row_pix[r][i]);
        end
        for (int t = NUM_POS - 1; t < acc_pix.size(); t++) begin
            for (int k = 0; k < NUM_KERNEL; k++) begin
                total = 0;
                for (int p = 0; p < NUM_POS; p++) begin
                    for (int c = 0; c < NUM_CHANNEL; c++) begin
                        total += elem_at(W_WORD'(acc_pix[t-NUM_POS+1+p]), c)
                               * elem_at(row_weight[r][p], k * NUM_CHANNEL + c);
                    end
                end
                word[k*BIT_WIDTH +: BIT_WIDTH] = clip_to_byte(total);
            end
            exp_out.push_back(word);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
        cyc++;
    endtask

    task automatic check_outputs(input int r);
        logic [O_WORD-1:0] got;
        logic [O_WORD-1:0] want;
        got = {o_psum_kn3, o_psum_kn2, o_psum_kn1, o_psum_kn0};
        if (due_q.size() > 0 && due_q[0] == cyc) begin
            assert (o_psum_val === 1'b1)
            else report_mismatch(row_name[r], "o_psum_val", 1, o_psum_val);
            want = exp_out[out_idx];
            for (int k = 0; k < NUM_KERNEL; k++) begin
                assert (got[k*BIT_WIDTH +: BIT_WIDTH] === want[k*BIT_WIDTH +: BIT_WIDTH])
                else report_mismatch(row_name[r], $sformatf("o_psum_kn%0d", k),
                                     $signed(want[k*BIT_WIDTH +: BIT_WIDTH]),
                                     $signed(got[k*BIT_WIDTH +: BIT_WIDTH]));
            end
            void'(due_q.pop_front());
            out_idx++;
        end else begin
            assert (o_psum_val === 1'b0)
            else report_mismatch(row_name[r], "o_psum_val", 0, o_psum_val);
        end
    endtask

    task automatic apply_reset(input int r);
        int waited;
        i_reset      = 1'b1;
        i_data_val   = 1'b0;
        i_weight_val = 1'b0;
        repeat (5) next_cycle();
        i_reset = 1'b0;
        due_q.delete();
        out_idx = 0;
        waited  = 0;
        while (o_weight_req !== 1'b1) begin
            if (waited >= WAIT_LIMIT) begin
                $display("Timeout: weight request did not return after reset");
                abort_run();
            end
            next_cycle();
            waited++;
        end
        assert (o_data_req === 1'b0) else report_mismatch(row_name[r], "o_data_req", 0, o_data_req);
        assert (o_psum_val === 1'b0) else report_mismatch(row_name[r], "o_psum_val", 0, o_psum_val);
    endtask

    // Junk pixels ride along while the taps load
    task automatic load_weights(input int r);
        for (int p = 0; p < NUM_POS; p++) begin
            assert (o_weight_req === 1'b1)
            else report_mismatch(row_name[r], "o_weight_req", 1, o_weight_req);
            assert (o_data_req === 1'b0)
            else report_mismatch(row_name[r], "o_data_req", 0, o_data_req);
            i_weight     = row_weight[r][p];
            i_weight_val = 1'b1;
            i_data       = D_WORD'(rand_word(NUM_CHANNEL, -128, 127));
            i_data_val   = 1'b1;
            next_cycle();
            check_outputs(r);
        end
        i_weight_val = 1'b0;
        i_data_val   = 1'b0;
        assert (o_weight_req === 1'b0)
        else report_mismatch(row_name[r], "o_weight_req", 0, o_weight_req);
        assert (o_data_req === 1'b1) else report_mismatch(row_name[r], "o_data_req", 1, o_data_req);
    endtask

    task automatic stream_pixels(input int r);
        int accepted;
        int waited;
        accepted = 0;
        for (int i = 0; i < row_len[r]; i++) begin
            i_data     = row_pix[r][i];
            i_data_val = row_val[r][i];
            if (row_val[r][i]) begin
                accepted++;
                // Output due two edges after the accepting edge
                if (accepted >= NUM_POS) due_q.push_back(cyc + 3);
            end
            next_cycle();
            check_outputs(r);
        end
        i_data_val = 1'b0;
        if (!row_cut[r]) begin
            waited = 0;
            while (due_q.size() > 0) begin
                if (waited >= WAIT_LIMIT) begin
                    $display("Timeout: convolution outputs missing in %s", row_name[r]);
                    abort_run();
                end
                next_cycle();
                check_outputs(r);
                waited++;
            end
            // No stray outputs after the last one
            repeat (2) begin
                next_cycle();
                check_outputs(r);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence

    initial begin
        i_reset      = 1'b1;
        i_data       = '0;
        i_data_val   = 1'b0;
        i_weight     = '0;
        i_weight_val = 1'b0;
        cyc          = 0;
        out_idx      = 0;
        void'($urandom(32'h3344));
        build_table();
        for (int r = 0; r < NUM_ROWS; r++) begin
            compute_expected(r);
            apply_reset(r);
            load_weights(r);
            stream_pixels(r);
        end
        $display("All checks passed");
        $finish;
    end

endmodule
